/* hw/axi2wb_pkg.sv */
package axi2wb_pkg;

	////////////////////////////////////////
	// AXI side field types
	////////////////////////////////////////

	// AWLEN as seen on the bus, beats minus one
	typedef logic [7:0] burst_len_t;

	// Up to 256 beats left, so one bit wider than AWLEN
	typedef logic [8:0] beat_cnt_t;

	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;  // Bus error reported by WB

	////////////////////////////////////////
	// Issuer FSM
	////////////////////////////////////////

	// IDLE waits for AW plus first beat
	// BURST issues the remaining beats
	// DRAIN swallows beats after a bus error
	typedef enum logic [1:0]
	{
		IDLE,
		BURST,
		DRAIN
	} issuer_state_t;

endpackage

/* hw/burst_evt_if.sv */
// Burst events from the issuer, seen by the ack tracker and the B queue
interface burst_evt_if #(
	parameter int ID_WIDTH = 4
) ();

	logic                   accept;      // AW and first beat taken
	axi2wb_pkg::burst_len_t len;         // Valid with accept
	logic [ID_WIDTH-1:0]    id;          // Valid with accept
	logic                   wlast_done;  // Final W beat taken

	// ID of a burst already in progress. A single-beat burst ends in its
	// own accept cycle and carries its ID on id instead
	logic [ID_WIDTH-1:0]    id_last;

	modport source (
		output accept,
		output len,
		output id,
		output wlast_done,
		output id_last
	);

	modport sink (
		input accept,
		input len,
		input id,
		input wlast_done,
		input id_last
	);

endinterface

/* hw/wr_burst_issuer.sv */
module wr_burst_issuer #(
	parameter int ID_WIDTH   = 4,
	parameter int ADDR_WIDTH = 16,
	parameter int DATA_WIDTH = 32,
	localparam int LSBS      = $clog2(DATA_WIDTH / 8),
	localparam int WB_AW     = ADDR_WIDTH - LSBS
) (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  logic [ID_WIDTH-1:0]     i_awid,
	input  logic [ADDR_WIDTH-1:0]   i_awaddr,
	input  axi2wb_pkg::burst_len_t  i_awlen,
	input  logic                    i_wvalid,
	output logic                    o_wready,
	input  logic [DATA_WIDTH-1:0]   i_wdata,
	input  logic [DATA_WIDTH/8-1:0] i_wstrb,
	input  logic                    i_wlast,
	output logic                    o_wb_cyc,
	output logic                    o_wb_stb,
	output logic [WB_AW-1:0]        o_wb_addr,
	output logic [DATA_WIDTH-1:0]   o_wb_data,
	output logic [DATA_WIDTH/8-1:0] o_wb_sel,
	input  logic                    i_wb_stall,
	input  logic                    i_wb_err,
	input  logic                    i_err_state,
	input  logic                    i_acks_idle,
	input  logic                    i_full,
	output logic                    o_drain_busy,
	burst_evt_if.source             evt
);

	axi2wb_pkg::issuer_state_t state;
	axi2wb_pkg::burst_len_t    rem;     // W beats still to take
	logic [ID_WIDTH-1:0]       cur_id;
	logic                      wb_fail;
	logic                      req_free;
	logic                      can_accept;
	logic                      accept;
	logic                      w_fire;
	logic                      issue;
	logic                      beat_last;

	assign wb_fail  = o_wb_cyc && i_wb_err;
	assign req_free = !o_wb_stb || !i_wb_stall;  // Request slot can take a beat

	assign can_accept = (state == axi2wb_pkg::IDLE) && !i_full && !i_err_state
		&& !wb_fail && req_free;
	assign o_awready = can_accept && i_wvalid;
	assign accept    = i_awvalid && o_awready;

	always_comb
	begin
		case (state)
		axi2wb_pkg::IDLE:  o_wready = can_accept && i_awvalid;
		axi2wb_pkg::BURST: o_wready = req_free && !wb_fail;
		default:           o_wready = 1'b1;  // Drain, discard each beat
		endcase
	end

	assign w_fire    = i_wvalid && o_wready;
	assign issue     = w_fire && (state != axi2wb_pkg::DRAIN);
	assign beat_last = (state == axi2wb_pkg::IDLE) ? (i_awlen == '0) : (rem == 8'd1);

	assign o_drain_busy = (state == axi2wb_pkg::DRAIN);

	assign evt.accept     = accept;
	assign evt.len        = i_awlen;
	assign evt.id         = i_awid;
	assign evt.wlast_done = w_fire && beat_last;
	assign evt.id_last    = cur_id;

	////////////////////////////////////////
	// Burst FSM
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state <= axi2wb_pkg::IDLE;
			rem   <= '0;
		end
		else
		begin
			case (state)
			axi2wb_pkg::IDLE:
				if (accept)
				begin
					rem <= i_awlen;
					if (i_awlen != '0)
						state <= axi2wb_pkg::BURST;
				end
			axi2wb_pkg::BURST:
				if (wb_fail)
					state <= axi2wb_pkg::DRAIN;  // Rest of the burst is dropped
				else if (w_fire)
				begin
					rem <= rem - 1'b1;
					if (rem == 8'd1)
						state <= axi2wb_pkg::IDLE;
				end
			default:
				if (w_fire)
				begin
					rem <= rem - 1'b1;
					if (rem == 8'd1)
						state <= axi2wb_pkg::IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Wishbone request
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (accept)
		begin
			cur_id    <= i_awid;
			o_wb_addr <= i_awaddr[ADDR_WIDTH-1:LSBS];
		end
		else if (issue)
			o_wb_addr <= o_wb_addr + 1'b1;  // One bus word per beat
		if (issue)
		begin
			o_wb_data <= i_wdata;
			o_wb_sel  <= i_wstrb;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || wb_fail)
		begin
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end
		else
		begin
			if (issue)
				o_wb_stb <= 1'b1;
			else if (req_free)
				o_wb_stb <= 1'b0;
			if (accept)
				o_wb_cyc <= 1'b1;
			else if ((state == axi2wb_pkg::IDLE) && i_acks_idle)
				o_wb_cyc <= 1'b0;  // Last ack is in, nothing new
		end
	end

	a_req_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(o_wb_stb && i_wb_stall && !i_wb_err) |=>
			(o_wb_stb && $stable(o_wb_addr) && $stable(o_wb_data) && $stable(o_wb_sel)))
		else $error("WB request changed under stall");

	a_stb_cyc: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_wb_stb |-> o_wb_cyc)
		else $error("WB stb without cyc");

	// Beat count from AWLEN must agree with the master's WLAST
	a_wlast: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		w_fire |-> (i_wlast == beat_last))
		else $error("WLAST does not match AWLEN");

endmodule

/* hw/ack_tracker.sv */
module ack_tracker #(
	parameter int LGFIFO = 3
) (
	input  logic     S_AXI_ACLK,
	input  logic     S_AXI_ARESETN,
	input  logic     i_wb_ack,
	input  logic     i_wb_err,
	input  logic     i_drain_busy,
	burst_evt_if.sink evt,
	output logic     o_err_state,
	output logic     o_acks_idle,
	output logic     o_stat_valid,
	output logic     o_stat_err
);

	localparam int DEPTH = 2 ** LGFIFO;

	axi2wb_pkg::burst_len_t len_mem [DEPTH];
	logic [LGFIFO-1:0]      wr_ptr;
	logic [LGFIFO-1:0]      rd_ptr;
	logic [LGFIFO:0]        fill;
	axi2wb_pkg::beat_cnt_t  cnt;
	axi2wb_pkg::beat_cnt_t  head_rem;   // Acks still owed by the head burst
	logic                   cnt_loaded;
	logic                   head_err;   // Sticky, head burst saw a bus error
	logic                   queued;
	logic                   ack_done;
	logic                   flush;
	logic                   pop;

	assign queued = (fill != '0);

	// Countdown starts from the queue entry until the first ack
	assign head_rem = cnt_loaded ? cnt : ({1'b0, len_mem[rd_ptr]} + 9'd1);

	assign ack_done = !o_err_state && i_wb_ack && queued && (head_rem == 9'd1);
	assign flush    = o_err_state && queued;  // One errored burst per cycle
	assign pop      = ack_done || flush;

	assign o_acks_idle = !queued || ((fill == 1) && ack_done);

	////////////////////////////////////////
	// Length queue
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (evt.accept)
			len_mem[wr_ptr] <= evt.len;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (evt.accept)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({evt.accept, pop})
			2'b10:   fill <= fill + 1'b1;
			2'b01:   fill <= fill - 1'b1;
			default: fill <= fill;
			endcase
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || pop)
			cnt_loaded <= 1'b0;
		else if (!o_err_state && i_wb_ack && queued)
			cnt_loaded <= 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_err_state && i_wb_ack && queued)
			cnt <= head_rem - 1'b1;
	end

	////////////////////////////////////////
	// Error handling and status
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_err_state <= 1'b0;
			head_err    <= 1'b0;
		end
		else
		begin
			if (i_wb_err)
				o_err_state <= 1'b1;
			else if (o_err_state && !queued && !i_drain_busy)
				o_err_state <= 1'b0;  // Flushed, and drained bursts are done
			if (i_wb_err)
				head_err <= 1'b1;
			else if (flush && (fill == 1))
				head_err <= 1'b0;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_stat_valid <= 1'b0;
		else
			o_stat_valid <= pop;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (pop)
			o_stat_err <= head_err;
	end

	// Every ack must answer a request of a queued burst
	a_ack_queued: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(i_wb_ack && !o_err_state) |-> queued)
		else $error("WB ack with no burst queued");

endmodule

/* hw/bresp_queue.sv */
module bresp_queue #(
	parameter int ID_WIDTH = 4,
	parameter int LGFIFO   = 3
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	burst_evt_if.sink             evt,
	input  logic                  i_stat_valid,
	input  logic                  i_stat_err,
	output logic                  o_bvalid,
	input  logic                  i_bready,
	output logic [ID_WIDTH-1:0]   o_bid,
	output axi2wb_pkg::axi_resp_t o_bresp,
	output logic                  o_full
);

	localparam int DEPTH = 2 ** LGFIFO;

	logic [ID_WIDTH-1:0] id_mem [DEPTH];
	logic [DEPTH-1:0]    err_mem;
	logic [LGFIFO:0]     id_wr;
	logic [LGFIFO:0]     st_wr;
	logic [LGFIFO:0]     rd;           // Shared, both queues pop together
	logic [LGFIFO:0]     id_fill;
	logic [LGFIFO:0]     st_fill;
	logic [LGFIFO:0]     outstanding;  // Accepted bursts not yet answered
	logic [ID_WIDTH-1:0] push_id;
	logic                b_fire;

	assign push_id = evt.accept ? evt.id : evt.id_last;
	assign id_fill = id_wr - rd;
	assign st_fill = st_wr - rd;
	assign b_fire  = o_bvalid && i_bready;
	assign o_full  = outstanding[LGFIFO];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (evt.wlast_done)
			id_mem[id_wr[LGFIFO-1:0]] <= push_id;
		if (i_stat_valid)
			err_mem[st_wr[LGFIFO-1:0]] <= i_stat_err;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			id_wr <= '0;
			st_wr <= '0;
		end
		else
		begin
			if (evt.wlast_done)
				id_wr <= id_wr + 1'b1;
			if (i_stat_valid)
				st_wr <= st_wr + 1'b1;
		end
	end

	////////////////////////////////////////
	// B channel
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_bvalid <= 1'b0;
			rd       <= '0;
		end
		else if (b_fire)
		begin
			o_bvalid <= 1'b0;
			rd       <= rd + 1'b1;
		end
		else if ((id_fill != '0) && (st_fill != '0))
			o_bvalid <= 1'b1;
	end

	// Held while BVALID waits for BREADY
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_bvalid)
		begin
			o_bid   <= id_mem[rd[LGFIFO-1:0]];
			o_bresp <= err_mem[rd[LGFIFO-1:0]] ? axi2wb_pkg::RESP_SLVERR
				: axi2wb_pkg::RESP_OKAY;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			outstanding <= '0;
		else
		begin
			case ({evt.accept, b_fire})
			2'b10:   outstanding <= outstanding + 1'b1;
			2'b01:   outstanding <= outstanding - 1'b1;
			default: outstanding <= outstanding;
			endcase
		end
	end

	// Issuer and tracker must respect the outstanding limit
	a_no_overflow: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!((evt.wlast_done && id_fill[LGFIFO]) || (i_stat_valid && st_fill[LGFIFO])))
		else $error("B queue pushed while full");

endmodule

/* hw/axi2wb_wr_bridge.sv */
module axi2wb_wr_bridge #(
	parameter int ID_WIDTH   = 4,
	parameter int ADDR_WIDTH = 16,  // Byte address
	parameter int DATA_WIDTH = 32,
	parameter int LGFIFO     = 3,
	localparam int WB_AW     = ADDR_WIDTH - $clog2(DATA_WIDTH / 8)
) (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  logic [ID_WIDTH-1:0]     i_awid,
	input  logic [ADDR_WIDTH-1:0]   i_awaddr,
	input  axi2wb_pkg::burst_len_t  i_awlen,
	input  logic                    i_wvalid,
	output logic                    o_wready,
	input  logic [DATA_WIDTH-1:0]   i_wdata,
	input  logic [DATA_WIDTH/8-1:0] i_wstrb,
	input  logic                    i_wlast,
	output logic                    o_bvalid,
	input  logic                    i_bready,
	output logic [ID_WIDTH-1:0]     o_bid,
	output axi2wb_pkg::axi_resp_t   o_bresp,
	output logic                    o_wb_cyc,
	output logic                    o_wb_stb,
	output logic [WB_AW-1:0]        o_wb_addr,
	output logic [DATA_WIDTH-1:0]   o_wb_data,
	output logic [DATA_WIDTH/8-1:0] o_wb_sel,
	input  logic                    i_wb_stall,
	input  logic                    i_wb_ack,
	input  logic                    i_wb_err
);

	logic err_state;
	logic acks_idle;
	logic stat_valid;
	logic stat_err;
	logic full;
	logic drain_busy;

	burst_evt_if #(.ID_WIDTH(ID_WIDTH)) evt ();

	wr_burst_issuer #(
		.ID_WIDTH  (ID_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	) issuer_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid    (i_awvalid),
		.o_awready    (o_awready),
		.i_awid       (i_awid),
		.i_awaddr     (i_awaddr),
		.i_awlen      (i_awlen),
		.i_wvalid     (i_wvalid),
		.o_wready     (o_wready),
		.i_wdata      (i_wdata),
		.i_wstrb      (i_wstrb),
		.i_wlast      (i_wlast),
		.o_wb_cyc     (o_wb_cyc),
		.o_wb_stb     (o_wb_stb),
		.o_wb_addr    (o_wb_addr),
		.o_wb_data    (o_wb_data),
		.o_wb_sel     (o_wb_sel),
		.i_wb_stall   (i_wb_stall),
		.i_wb_err     (i_wb_err),
		.i_err_state  (err_state),
		.i_acks_idle  (acks_idle),
		.i_full       (full),
		.o_drain_busy (drain_busy),
		.evt          (evt.source)
	);

	ack_tracker #(
		.LGFIFO(LGFIFO)
	) tracker_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wb_ack     (i_wb_ack),
		.i_wb_err     (i_wb_err),
		.i_drain_busy (drain_busy),
		.evt          (evt.sink),
		.o_err_state  (err_state),
		.o_acks_idle  (acks_idle),
		.o_stat_valid (stat_valid),
		.o_stat_err   (stat_err)
	);

	bresp_queue #(
		.ID_WIDTH(ID_WIDTH),
		.LGFIFO  (LGFIFO)
	) bresp_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.evt          (evt.sink),
		.i_stat_valid (stat_valid),
		.i_stat_err   (stat_err),
		.o_bvalid     (o_bvalid),
		.i_bready     (i_bready),
		.o_bid        (o_bid),
		.o_bresp      (o_bresp),
		.o_full       (full)
	);

endmodule

/* verification/tb_clkgen.sv */
module tb_clkgen #(
	parameter int HALF_PERIOD  = 5,
	parameter int RESET_CYCLES = 5
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial
	begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	// Active low, released on a rising edge
	initial
	begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

/* verification/axi2wb_wr_bridge_tb.sv */
module axi2wb_wr_bridge_tb;

	localparam int ID_WIDTH   = 4;
	localparam int ADDR_WIDTH = 16;
	localparam int DATA_WIDTH = 32;
	localparam int LGFIFO     = 3;
	localparam int LSBS       = $clog2(DATA_WIDTH / 8);
	localparam int WB_AW      = ADDR_WIDTH - LSBS;

	localparam int NUM_TESTS       = 5;
	localparam int TOTAL_BEATS     = 48;  // Sum of beats over all tests
	localparam int WATCHDOG_CYCLES = NUM_TESTS * TOTAL_BEATS * 20;

	logic clk;
	logic rst_n;

	logic                        awvalid = 1'b0;
	logic [ID_WIDTH-1:0]         awid    = '0;
	logic [ADDR_WIDTH-1:0]       awaddr  = '0;
	axi2wb_pkg::burst_len_t      awlen   = '0;
	logic                        wvalid  = 1'b0;
	logic [DATA_WIDTH-1:0]       wdata   = '0;
	logic [DATA_WIDTH/8-1:0]     wstrb   = '0;
	logic                        wlast   = 1'b0;
	logic                        bready  = 1'b0;
	logic                        wb_stall = 1'b0;
	logic                        wb_ack  = 1'b0;
	logic                        wb_err  = 1'b0;
	logic                        awready;
	logic                        wready;
	logic                        o_bvalid;
	logic [ID_WIDTH-1:0]         o_bid;
	axi2wb_pkg::axi_resp_t       o_bresp;
	logic                        o_wb_cyc;
	logic                        o_wb_stb;
	logic [WB_AW-1:0]            o_wb_addr;
	logic [DATA_WIDTH-1:0]       o_wb_data;
	logic [DATA_WIDTH/8-1:0]     o_wb_sel;

	logic aw_fire;
	logic w_fire;
	logic b_fire;

	// Expected traffic
	logic                        exp_valid;
	logic [WB_AW-1:0]            exp_addr;
	logic [DATA_WIDTH-1:0]       exp_data;
	logic [DATA_WIDTH/8-1:0]     exp_sel;
	logic [WB_AW-1:0]            next_word;
	logic                        in_burst;   // More W beats of this burst to come
	logic                        dropping;   // Beats drained after a bus error
	logic                        held_q;
	logic [ID_WIDTH-1:0]         bexp_id [64];
	axi2wb_pkg::axi_resp_t       bexp_resp [64];
	logic [ID_WIDTH-1:0]         head_bid;
	axi2wb_pkg::axi_resp_t       head_bresp;
	int                          ack_burst [$];
	int                          ack_left [$];
	int                          n_aw;
	int                          n_b;
	int                          n_slverr;
	int                          n_stalled;
	int                          stall_mark;
	int                          n_taken;
	int                          err_beat = -1;
	int                          stall_bits = 2;
	int                          n_errors = 0;
	int                          n_ok = 0;
	int                          err_mark = 0;
	logic [31:0]                 lfsr_state;
	logic [31:0]                 rnd;

	tb_clkgen #(.HALF_PERIOD(5), .RESET_CYCLES(5)) clkgen_i (
		.o_clk  (clk),
		.o_rst_n(rst_n)
	);

	axi2wb_wr_bridge #(
		.ID_WIDTH  (ID_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.LGFIFO    (LGFIFO)
	) axi2wb_wr_bridge_i (
		.S_AXI_ACLK   (clk),
		.S_AXI_ARESETN(rst_n),
		.i_awvalid    (awvalid),
		.o_awready    (awready),
		.i_awid       (awid),
		.i_awaddr     (awaddr),
		.i_awlen      (awlen),
		.i_wvalid     (wvalid),
		.o_wready     (wready),
		.i_wdata      (wdata),
		.i_wstrb      (wstrb),
		.i_wlast      (wlast),
		.o_bvalid     (o_bvalid),
		.i_bready     (bready),
		.o_bid        (o_bid),
		.o_bresp      (o_bresp),
		.o_wb_cyc     (o_wb_cyc),
		.o_wb_stb     (o_wb_stb),
		.o_wb_addr    (o_wb_addr),
		.o_wb_data    (o_wb_data),
		.o_wb_sel     (o_wb_sel),
		.i_wb_stall   (wb_stall),
		.i_wb_ack     (wb_ack),
		.i_wb_err     (wb_err)
	);

	assign aw_fire    = awvalid && awready;
	assign w_fire     = wvalid && wready;
	assign b_fire     = o_bvalid && bready;
	assign head_bid   = bexp_id[n_b[5:0]];
	assign head_bresp = bexp_resp[n_b[5:0]];

	task automatic report_wrong_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		n_errors++;
		$display("MISMATCH %s: got %0h, expected %0h at %0t", name, got, exp, $time);
	endtask

	task automatic note_failure(input string what);
		n_errors++;
		$display("ERROR: %s at %0t", what, $time);
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
				: (lfsr_state >> 1);
		end
		return v;
	endfunction

	// Byte address to bus word address
	function automatic logic [WB_AW-1:0] word_addr(input logic [ADDR_WIDTH-1:0] addr);
		return WB_AW'(addr / (DATA_WIDTH / 8));
	endfunction

	function automatic logic [DATA_WIDTH-1:0] beat_data(input logic [ID_WIDTH-1:0] id,
		input int beat, input logic [ADDR_WIDTH-1:0] addr);
		return {id, beat[11:0], addr};
	endfunction

	////////////////////////////////////////
	// Wishbone slave, stall and BREADY
	////////////////////////////////////////

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_ack     <= 1'b0;
			wb_err     <= 1'b0;
			wb_stall   <= 1'b0;
			bready     <= 1'b0;
			n_taken    <= 0;
			lfsr_state = 32'h823f;
		end
		else
		begin
			wb_ack <= 1'b0;
			wb_err <= 1'b0;
			if (o_wb_cyc && o_wb_stb && !wb_stall && !wb_err)  // Not taken when aborted
			begin
				if (n_taken == err_beat)
					wb_err <= 1'b1;
				else
					wb_ack <= 1'b1;
				n_taken <= n_taken + 1;
			end
			rnd = lfsr_bits(stall_bits);
			wb_stall <= (rnd == ((32'd1 << stall_bits) - 1));
			rnd = lfsr_bits(1);
			bready <= rnd[0];
		end
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			exp_valid <= 1'b0;
			in_burst  <= 1'b0;
			dropping  <= 1'b0;
			held_q    <= 1'b0;
			n_aw      <= 0;
			n_b       <= 0;
			n_slverr  <= 0;
			n_stalled <= 0;
			ack_burst.delete();
			ack_left.delete();
		end
		else
		begin
			held_q    <= o_wb_stb && wb_stall;
			exp_valid <= 1'b0;
			if (o_wb_stb && wb_stall)
				n_stalled <= n_stalled + 1;
			if (w_fire)
			begin
				if (!dropping)
				begin
					exp_valid <= 1'b1;
					exp_addr  <= aw_fire ? word_addr(awaddr) : next_word;
					exp_data  <= wdata;
					exp_sel   <= wstrb;
				end
				next_word <= (aw_fire ? word_addr(awaddr) : next_word) + 1'b1;
				in_burst  <= !wlast;
				if (wlast)
					dropping <= 1'b0;
			end
			if (wb_err && in_burst)
				dropping <= 1'b1;  // Rest of the burst is swallowed
			if (wb_ack && (ack_left.size() != 0))
			begin
				if (ack_left[0] == 1)
				begin
					void'(ack_left.pop_front());
					void'(ack_burst.pop_front());
				end
				else
					ack_left[0] = ack_left[0] - 1;
			end
			if (wb_err)
			begin
				foreach (ack_burst[k])
					bexp_resp[ack_burst[k] % 64] <= axi2wb_pkg::RESP_SLVERR;
				ack_burst.delete();
				ack_left.delete();
			end
			if (aw_fire)
			begin
				bexp_id[n_aw % 64]   <= awid;
				bexp_resp[n_aw % 64] <= axi2wb_pkg::RESP_OKAY;
				ack_burst.push_back(n_aw);
				ack_left.push_back(int'(awlen) + 1);
				n_aw <= n_aw + 1;
			end
			if (b_fire)
			begin
				n_b <= n_b + 1;
				if (o_bresp == axi2wb_pkg::RESP_SLVERR)
					n_slverr <= n_slverr + 1;
			end
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	a_req_seen: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid |-> o_wb_stb) else note_failure("no request after a W beat");
	a_req_addr: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid |-> (o_wb_addr == exp_addr))
		else report_wrong_value("o_wb_addr", $sampled(o_wb_addr), $sampled(exp_addr));
	a_req_data: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid |-> (o_wb_data == exp_data))
		else report_wrong_value("o_wb_data", $sampled(o_wb_data), $sampled(exp_data));
	a_req_sel: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid |-> (o_wb_sel == exp_sel))
		else report_wrong_value("o_wb_sel", $sampled(o_wb_sel), $sampled(exp_sel));
	a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
		o_wb_stb |-> (exp_valid || held_q)) else note_failure("request without a W beat");

	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(o_wb_stb && wb_stall && !wb_err) |=>
			(o_wb_stb && $stable(o_wb_addr) && $stable(o_wb_data) && $stable(o_wb_sel)))
		else note_failure("request changed while stalled");
	a_stall_no_w: assert property (@(posedge clk) disable iff (!rst_n)
		(o_wb_stb && wb_stall) |-> !w_fire) else note_failure("W beat taken under stall");
	a_err_drop: assert property (@(posedge clk) disable iff (!rst_n)
		wb_err |=> !o_wb_cyc) else note_failure("cyc still high after a bus error");

	a_b_pending: assert property (@(posedge clk) disable iff (!rst_n)
		o_bvalid |-> (n_b < n_aw)) else note_failure("B response with no burst outstanding");
	a_bid: assert property (@(posedge clk) disable iff (!rst_n)
		b_fire |-> (o_bid == head_bid))
		else report_wrong_value("o_bid", $sampled(o_bid), $sampled(head_bid));
	a_bresp: assert property (@(posedge clk) disable iff (!rst_n)
		b_fire |-> (o_bresp == head_bresp))
		else report_wrong_value("o_bresp", $sampled(o_bresp), $sampled(head_bresp));
	a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(o_bvalid && !bready) |=> (o_bvalid && $stable(o_bid) && $stable(o_bresp)))
		else note_failure("B channel changed while BREADY low");

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic write_burst(input logic [ID_WIDTH-1:0] id,
		input logic [ADDR_WIDTH-1:0] addr, input int len);
		int beat;
		beat = 0;
		awvalid <= 1'b1;
		awid    <= id;
		awaddr  <= addr;
		awlen   <= 8'(len);
		wvalid  <= 1'b1;
		wdata   <= beat_data(id, 0, addr);
		wstrb   <= 4'hf;
		wlast   <= (len == 0);
		while (beat <= len)
		begin
			@(posedge clk);
			if (aw_fire)
				awvalid <= 1'b0;
			if (w_fire)
			begin
				beat++;
				if (beat > len)
					wvalid <= 1'b0;
				else
				begin
					wdata <= beat_data(id, beat, addr);
					wstrb <= 4'hf ^ beat[3:0];
					wlast <= (beat == len);
				end
			end
		end
	endtask

	// Waits for every B, then reports the test
	task automatic finish_test(input int num, input string name);
		@(posedge clk);
		while (n_b != n_aw)
			@(posedge clk);
		if (n_errors == err_mark)
			n_ok++;
		$display("test %0d %s: %s", num, name, (n_errors == err_mark) ? "ok" : "fail");
		err_mark = n_errors;
	endtask

	initial
	begin
		@(posedge rst_n);
		@(posedge clk);
		if (o_wb_cyc || o_wb_stb || o_bvalid)
			note_failure("Wishbone or B channel active after reset");
		write_burst(4'h3, 16'h0124, 0);
		finish_test(1, "single beat");
		write_burst(4'h5, 16'h0400, 7);
		finish_test(2, "burst of 8");
		stall_mark = n_stalled;
		stall_bits <= 1;  // Heavier stall
		write_burst(4'h9, 16'h0800, 15);
		if (n_stalled == stall_mark)
			note_failure("no stalled request in stall test");
		finish_test(3, "stall hold");
		stall_bits <= 2;
		write_burst(4'h1, 16'h1000, 2);
		write_burst(4'h2, 16'h1100, 0);
		write_burst(4'h3, 16'h1200, 5);
		write_burst(4'h4, 16'h1300, 1);
		finish_test(4, "back to back");
		err_beat <= n_taken + 5;  // Fourth beat of the second burst
		write_burst(4'h6, 16'h2000, 1);
		write_burst(4'h7, 16'h2100, 5);
		write_burst(4'h8, 16'h2200, 2);
		finish_test(5, "bus error");
		if (n_slverr != 1)
			note_failure("error test did not give exactly one SLVERR");
		err_beat <= -1;
		$display("tests %0d, ok %0d, errors %0d", NUM_TESTS, n_ok, n_errors);
		if (n_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* files.f */
hw/axi2wb_pkg.sv
hw/burst_evt_if.sv
hw/wr_burst_issuer.sv
hw/ack_tracker.sv
hw/bresp_queue.sv
hw/axi2wb_wr_bridge.sv
verification/tb_clkgen.sv
verification/axi2wb_wr_bridge_tb.sv

/* Bender.yml */
package:
  name: axi2wb_wr_bridge

sources:
  - hw/axi2wb_pkg.sv
  - hw/burst_evt_if.sv
  - hw/wr_burst_issuer.sv
  - hw/ack_tracker.sv
  - hw/bresp_queue.sv
  - hw/axi2wb_wr_bridge.sv
  - target: test
    files:
      - verification/tb_clkgen.sv
      - verification/axi2wb_wr_bridge_tb.sv
